/* hw/wiscPkg.sv */
// Shared types for the core: opcode, ALU function and execute state enums
// plus the memory request, memory response and register write structs
`default_nettype none
package wiscPkg;

   // Primary opcodes live in instruction bits 15:11
   typedef enum logic [4:0] {
      HALT  = 5'b00000,
      NOP   = 5'b00001,
      J     = 5'b00100,   // PC relative, 11-bit displacement
      JR    = 5'b00101,   // Rs plus 8-bit immediate
      JAL   = 5'b00110,
      JALR  = 5'b00111,
      ADDI  = 5'b01000,
      BEQZ  = 5'b01100,
      BNEZ  = 5'b01101,
      BLTZ  = 5'b01110,
      BGEZ  = 5'b01111,
      ST    = 5'b10000,
      LD    = 5'b10001,
      LBI   = 5'b11000,
      RTYPE = 5'b11011    // Function in bits 1:0, Rd in bits 4:2
   } opcodeE;

   typedef enum logic [1:0] {
      ADD  = 2'b00,
      SUB  = 2'b01,   // Rt minus Rs as the ISA defines it
      XOR  = 2'b10,
      ANDN = 2'b11    // Rs and the inverse of Rt
   } aluFuncE;

   // Execute either accepts a new instruction or waits on memory
   typedef enum logic {
      ISSUE,
      MEMWAIT
   } exStateE;

   typedef struct packed {
      logic        strobe;   // Request is present this cycle
      logic        wrEn;
      logic [15:0] addr;     // Byte address with bit 0 ignored
      logic [15:0] wrData;
   } memReqT;

   typedef struct packed {
      logic        valid;    // One-cycle response pulse
      logic [15:0] data;
   } memRspT;

   typedef struct packed {
      logic        en;
      logic [2:0]  addr;
      logic [15:0] data;
   } regWriteT;

endpackage
`default_nettype wire

/* hw/regFile.sv */
// Eight by 16-bit register file with two asynchronous read ports and one write port
`timescale 1ns/1ps
`default_nettype none
module regFile (
   input  wire                    clk,
   input  wire                    rst,
   input  wire [2:0]              rdAddrA,
   input  wire [2:0]              rdAddrB,
   output logic [15:0]            rdDataA,
   output logic [15:0]            rdDataB,
   input  wire wiscPkg::regWriteT wr
);

   logic [15:0] regs [8];

   // Reads see the old value during a write, the new one shows up next cycle
   assign rdDataA = regs[rdAddrA];
   assign rdDataB = regs[rdAddrB];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= 16'h0000;   // All registers start at zero
         end
      end else if (wr.en) begin
         regs[wr.addr] <= wr.data;
      end
   end

endmodule
`default_nettype wire

/* hw/decode.sv */
// Decode stage with field extraction, immediate extension, register write select,
// branch and jump resolution around the register file
`timescale 1ns/1ps
`default_nettype none
module decode (
   input  wire                    clk,
   input  wire                    rst,
   input  wire [15:0]             instr,
   input  wire [15:0]             pc,
   input  wire                    issue,
   input  wire wiscPkg::regWriteT wb,
   output logic [15:0]            rsData,
   output logic [15:0]            rtData,
   output logic [15:0]            imm,
   output logic [15:0]            target,
   output logic                   pcSel,
   output wiscPkg::regWriteT      retire
);
   import wiscPkg::*;

   opcodeE      op;
   logic [15:0] pcPlus2;   // Link value and base of relative targets
   logic        rsZero;
   logic        rsNeg;
   logic        taken;

   assign op      = opcodeE'(instr[15:11]);
   assign pcPlus2 = pc + 16'd2;
   assign rsZero  = (rsData == 16'h0000);
   assign rsNeg   = rsData[15];   // Sign bit of Rs

   // Rs always sits in bits 10:8 and Rt in bits 7:5
   regFile regs (.clk(clk), .rst(rst), .rdAddrA(instr[10:8]), .rdAddrB(instr[7:5]),
                 .rdDataA(rsData), .rdDataB(rtData), .wr(retire));

   // Immediate width depends on the instruction format
   always_comb begin
      case (op)
         ADDI, LD, ST: imm = {{11{instr[4]}}, instr[4:0]};
         J, JAL:       imm = {{5{instr[10]}}, instr[10:0]};
         default:      imm = {{8{instr[7]}}, instr[7:0]};   // LBI, branches, JR, JALR
      endcase
   end

   always_comb begin
      case (op)
         BEQZ:                taken = rsZero;
         BNEZ:                taken = !rsZero;
         BLTZ:                taken = rsNeg;
         BGEZ:                taken = !rsNeg;
         J, JR, JAL, JALR:    taken = 1'b1;   // Jumps always redirect
         default:             taken = 1'b0;
      endcase
   end

   assign pcSel  = issue && taken;
   // Register jumps add to Rs, everything else is relative to the next PC
   assign target = (op == JR || op == JALR) ? rsData + imm : pcPlus2 + imm;

   // LBI and the linking jumps write here, the rest comes back from execute
   always_comb begin
      retire = wb;
      if (issue && op == LBI) begin
         retire.en   = 1'b1;
         retire.addr = instr[10:8];   // LBI targets Rs
         retire.data = imm;
      end else if (issue && (op == JAL || op == JALR)) begin
         retire.en   = 1'b1;
         retire.addr = 3'd7;
         retire.data = pcPlus2;   // Return address goes to R7
      end
   end

endmodule
`default_nettype wire

/* hw/fetch.sv */
// Fetch unit with program counter, instruction request and one-entry instruction buffer
`timescale 1ns/1ps
`default_nettype none
module fetch #(
   parameter logic [15:0] resetPc = 16'h0000
) (
   input  wire                   clk,
   input  wire                   rst,
   output wiscPkg::memReqT       req,
   input  wire                   grant,
   input  wire wiscPkg::memRspT  rsp,
   input  wire                   consume,
   input  wire                   pcSel,
   input  wire [15:0]            target,
   input  wire                   halt,
   output logic [15:0]           instr,
   output logic [15:0]           instrPc,
   output logic                  instrValid
);

   logic [15:0] pc;
   logic [15:0] instrBuf;
   logic        bufValid;
   logic        pending;   // A granted read of ours is in flight
   logic        fill;

   // Responses with no read of ours outstanding are stale and dropped
   assign fill       = pending && rsp.valid;
   assign instrValid = bufValid || fill;   // The response is usable in its own cycle
   assign instr      = bufValid ? instrBuf : rsp.data;
   assign instrPc    = pc;   // PC only moves on consume so it still names the buffered word

   always_comb begin
      req        = '0;
      req.strobe = !bufValid && !pending && !halt;
      req.addr   = pc;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pc       <= resetPc;
         bufValid <= 1'b0;
         pending  <= 1'b0;
      end else begin
         if (req.strobe && grant) pending <= 1'b1;
         else if (fill) pending <= 1'b0;
         if (consume) begin
            bufValid <= 1'b0;
            pc       <= pcSel ? target : pc + 16'd2;   // Redirect wins over sequential
         end else if (fill) begin
            bufValid <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fill) instrBuf <= rsp.data;
   end

endmodule
`default_nettype wire

/* hw/execute.sv */
// Execute unit with issue control, ALU and the load and store FSM
`timescale 1ns/1ps
`default_nettype none
module execute (
   input  wire                  clk,
   input  wire                  rst,
   input  wire [15:0]           instr,
   input  wire                  instrValid,
   input  wire [15:0]           rsData,
   input  wire [15:0]           rtData,
   input  wire [15:0]           imm,
   output wiscPkg::memReqT      req,
   input  wire                  grant,
   input  wire wiscPkg::memRspT rsp,
   output logic                 consume,
   output wiscPkg::regWriteT    wb,
   output logic                 halted
);
   import wiscPkg::*;

   exStateE     state;
   opcodeE      op;
   aluFuncE     func;
   logic [15:0] aluOut;
   logic [15:0] memAddr;
   logic [15:0] memData;
   logic [2:0]  memDest;
   logic        isLoad;
   logic        sent;   // Request was granted, now waiting for load data

   assign op      = opcodeE'(instr[15:11]);
   assign func    = aluFuncE'(instr[1:0]);
   assign consume = (state == ISSUE) && instrValid && !halted;

   always_comb begin
      case (func)
         ADD:     aluOut = rsData + rtData;
         SUB:     aluOut = rtData - rsData;
         XOR:     aluOut = rsData ^ rtData;
         default: aluOut = rsData & ~rtData;
      endcase
      if (op == ADDI) aluOut = rsData + imm;
   end

   // ALU results retire on issue, load data retires on its response
   always_comb begin
      wb = '0;
      if (consume && (op == ADDI || op == RTYPE)) begin
         wb.en   = 1'b1;
         wb.addr = (op == ADDI) ? instr[7:5] : instr[4:2];
         wb.data = aluOut;
      end else if (state == MEMWAIT && sent && rsp.valid) begin
         wb.en   = 1'b1;
         wb.addr = memDest;
         wb.data = rsp.data;
      end
   end

   always_comb begin
      req.strobe = (state == MEMWAIT) && !sent;   // Held until the arbiter grants it
      req.wrEn   = !isLoad;
      req.addr   = memAddr;
      req.wrData = memData;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state  <= ISSUE;
         sent   <= 1'b0;
         halted <= 1'b0;
      end else begin
         case (state)
            ISSUE: begin
               if (consume && (op == LD || op == ST)) state <= MEMWAIT;
               if (consume && op == HALT) halted <= 1'b1;
            end
            MEMWAIT: begin
               if (req.strobe && grant) sent <= 1'b1;
               // A store is done once granted, a load once its data is back
               if ((req.strobe && grant && !isLoad) || (sent && rsp.valid)) begin
                  state <= ISSUE;
                  sent  <= 1'b0;
               end
            end
            default: state <= ISSUE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (consume) begin
         memAddr <= rsData + imm;
         memData <= rtData;       // Store data comes from the Rt field
         memDest <= instr[7:5];
         isLoad  <= (op == LD);
      end
   end

endmodule
`default_nettype wire

/* hw/memArbiter.sv */
// Fixed-priority memory arbiter with data over fetch and response steering
`timescale 1ns/1ps
`default_nettype none
module memArbiter (
   input  wire wiscPkg::memReqT instReq,
   input  wire wiscPkg::memReqT dataReq,
   output logic                 instGrant,
   output logic                 dataGrant,
   output wiscPkg::memReqT      memReq,
   input  wire wiscPkg::memRspT memRsp,
   output wiscPkg::memRspT      instRsp,
   output wiscPkg::memRspT      dataRsp,
   input  wire                  clk,
   input  wire                  rst
);

   logic rdPending;     // Read launched last cycle
   logic rdOwnerData;   // Owner of that read

   assign dataGrant = dataReq.strobe;                      // Data side always wins
   assign instGrant = instReq.strobe && !dataReq.strobe;
   assign memReq    = dataReq.strobe ? dataReq : instReq;

   always_ff @(posedge clk) begin
      if (rst) begin
         rdPending   <= 1'b0;
         rdOwnerData <= 1'b0;
      end else begin
         rdPending   <= memReq.strobe && !memReq.wrEn;
         rdOwnerData <= dataGrant;
      end
   end

   // Only the owner sees the pulse, data goes to both
   always_comb begin
      instRsp       = memRsp;
      dataRsp       = memRsp;
      instRsp.valid = memRsp.valid && rdPending && !rdOwnerData;
      dataRsp.valid = memRsp.valid && rdPending && rdOwnerData;
   end

endmodule
`default_nettype wire

/* hw/sharedMem.sv */
// Single-port word memory with registered read and a load port
`timescale 1ns/1ps
`default_nettype none
module sharedMem #(
   parameter int memWords = 256
) (
   input  wire                  clk,
   input  wire wiscPkg::memReqT req,
   output wiscPkg::memRspT      rsp,
   input  wire                  loadEn,
   input  wire [15:0]           loadAddr,
   input  wire [15:0]           loadData
);

   localparam int idxW = $clog2(memWords);

   logic [15:0]     mem [memWords];
   logic [idxW-1:0] reqIdx;
   logic [idxW-1:0] loadIdx;

   assign reqIdx  = req.addr[idxW:1];   // Word index from the byte address
   assign loadIdx = loadAddr[idxW:1];

   always_ff @(posedge clk) begin
      if (loadEn) mem[loadIdx] <= loadData;   // Preload has priority
      else if (req.strobe && req.wrEn) mem[reqIdx] <= req.wrData;
   end

   always_ff @(posedge clk) begin
      rsp.valid <= req.strobe && !req.wrEn;
      rsp.data  <= mem[reqIdx];
   end

endmodule
`default_nettype wire

/* hw/cpuTop.sv */
// Core top level joining fetch, decode, execute, the arbiter and the shared memory
`timescale 1ns/1ps
`default_nettype none
module cpuTop #(
   parameter int          memWords = 256,
   parameter logic [15:0] resetPc  = 16'h0000
) (
   input  wire               clk,
   input  wire               rst,
   input  wire               loadEn,
   input  wire [15:0]        loadAddr,
   input  wire [15:0]        loadData,
   output wiscPkg::regWriteT retire,
   output logic              halted
);
   import wiscPkg::*;

   memReqT      instReq, dataReq, memReq;
   memRspT      instRsp, dataRsp, memRsp;
   regWriteT    wb;
   logic        instGrant, dataGrant;
   logic        consume, pcSel, instrValid;
   logic [15:0] instr, instrPc, rsData, rtData, imm, target;

   fetch #(.resetPc(resetPc)) fetchU (.clk(clk), .rst(rst), .req(instReq), .grant(instGrant),
      .rsp(instRsp), .consume(consume), .pcSel(pcSel), .target(target), .halt(halted),
      .instr(instr), .instrPc(instrPc), .instrValid(instrValid));

   decode decodeU (.clk(clk), .rst(rst), .instr(instr), .pc(instrPc), .issue(consume),
      .wb(wb), .rsData(rsData), .rtData(rtData), .imm(imm), .target(target),
      .pcSel(pcSel), .retire(retire));

   execute executeU (.clk(clk), .rst(rst), .instr(instr), .instrValid(instrValid),
      .rsData(rsData), .rtData(rtData), .imm(imm), .req(dataReq), .grant(dataGrant),
      .rsp(dataRsp), .consume(consume), .wb(wb), .halted(halted));

   memArbiter arbU (.instReq(instReq), .dataReq(dataReq), .instGrant(instGrant),
      .dataGrant(dataGrant), .memReq(memReq), .memRsp(memRsp), .instRsp(instRsp),
      .dataRsp(dataRsp), .clk(clk), .rst(rst));

   // Preload only counts while the core is held in reset
   sharedMem #(.memWords(memWords)) memU (.clk(clk), .req(memReq), .rsp(memRsp),
      .loadEn(loadEn && rst), .loadAddr(loadAddr), .loadData(loadData));

endmodule
`default_nettype wire

/* test/clockGen.sv */
// Free-running testbench clock with a 4 ns period
`timescale 1ns/1ps
`default_nettype none
module clockGen (
   output logic clk
);

   initial clk = 1'b0;
   always #2 clk = ~clk;   // Half period of 2 ns

endmodule
`default_nettype wire

/* test/cpuTb.sv */
// Testbench for the core with program builders, the ISA reference model,
// the retire checker, the timeout watchdog and the five directed and random tests
`timescale 1ns/1ps
`default_nettype none
module cpuTb;
   import wiscPkg::*;

   logic        clk;
   logic        rst;
   logic        loadEn;
   logic [15:0] loadAddr;
   logic [15:0] loadData;
   regWriteT    retire;
   logic        halted;

   logic [15:0] prog [256];    // Memory image of the program under test
   int          progLen;
   logic [18:0] expQ [$];      // Expected retires as register number and data
   logic [18:0] expEntry;
   int          errCount;
   int          cycleCount;
   int          cycleLimit;
   logic        running;       // Watchdog counts only while a program runs
   logic [4:0]  off;
   int unsigned seedSink;

   clockGen clkGen (.clk(clk));

   cpuTop #(.memWords(256), .resetPc(16'h0000)) UUT (.clk(clk), .rst(rst), .loadEn(loadEn),
      .loadAddr(loadAddr), .loadData(loadData), .retire(retire), .halted(halted));

   // Instruction formats
   function automatic logic [15:0] shortImm(opcodeE op, logic [2:0] rs, logic [2:0] rt,
                                            logic [4:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic logic [15:0] byteImm(opcodeE op, logic [2:0] rs, logic [7:0] imm);
      return {op, rs, imm};
   endfunction

   function automatic logic [15:0] regOp(logic [2:0] rs, logic [2:0] rt, logic [2:0] rd,
                                         aluFuncE f);
      return {RTYPE, rs, rt, rd, f};
   endfunction

   function automatic logic [15:0] longJump(opcodeE op, logic [10:0] disp);
      return {op, disp};
   endfunction

   task automatic clearProgram();
      for (int i = 0; i < 256; i++) prog[i] = {8'(i), ~8'(i)};   // Address dependent fill
      progLen = 0;
   endtask

   task automatic emit(input logic [15:0] w);
      prog[progLen] = w;
      progLen++;
   endtask

   // ISA model that walks the image from the reset PC and queues every register write
   function automatic void buildExpected();
      logic [15:0] r [8];
      logic [15:0] m [256];
      logic [15:0] pc;
      logic [15:0] nextPc;
      logic [15:0] w;
      logic [15:0] ea;
      logic [15:0] i5;
      logic [15:0] i8;
      logic [15:0] i11;
      logic [2:0]  rs;
      logic [2:0]  rt;
      logic [2:0]  rd;
      opcodeE      op;
      bit          done;
      int          steps;
      expQ.delete();
      for (int i = 0; i < 8; i++) r[i] = 16'h0000;
      for (int i = 0; i < 256; i++) m[i] = prog[i];
      pc = 16'h0000;
      done = 1'b0;
      steps = 0;
      while (!done && steps < 2000) begin
         w = m[pc[8:1]];
         op = opcodeE'(w[15:11]);
         rs = w[10:8];
         rt = w[7:5];
         rd = w[4:2];
         i5 = {{11{w[4]}}, w[4:0]};
         i8 = {{8{w[7]}}, w[7:0]};
         i11 = {{5{w[10]}}, w[10:0]};
         nextPc = pc + 16'd2;
         case (op)
            LBI: begin
               r[rs] = i8;
               expQ.push_back({rs, r[rs]});
            end
            ADDI: begin
               r[rt] = r[rs] + i5;   // Destination is the Rt field
               expQ.push_back({rt, r[rt]});
            end
            RTYPE: begin
               case (w[1:0])
                  2'b00:   r[rd] = r[rs] + r[rt];
                  2'b01:   r[rd] = r[rt] - r[rs];   // Subtract is Rt minus Rs
                  2'b10:   r[rd] = r[rs] ^ r[rt];
                  default: r[rd] = r[rs] & ~r[rt];
               endcase
               expQ.push_back({rd, r[rd]});
            end
            ST: begin
               ea = r[rs] + i5;
               m[ea[8:1]] = r[rt];
            end
            LD: begin
               ea = r[rs] + i5;
               r[rt] = m[ea[8:1]];
               expQ.push_back({rt, r[rt]});
            end
            BEQZ: if (r[rs] == 16'h0000) nextPc = pc + 16'd2 + i8;
            BNEZ: if (r[rs] != 16'h0000) nextPc = pc + 16'd2 + i8;
            BLTZ: if (r[rs][15]) nextPc = pc + 16'd2 + i8;
            BGEZ: if (!r[rs][15]) nextPc = pc + 16'd2 + i8;
            J:    nextPc = pc + 16'd2 + i11;
            JR:   nextPc = r[rs] + i8;
            JAL: begin
               nextPc = pc + 16'd2 + i11;
               r[7] = pc + 16'd2;
               expQ.push_back({3'd7, r[7]});
            end
            JALR: begin
               nextPc = r[rs] + i8;   // Target uses Rs before the link lands
               r[7] = pc + 16'd2;
               expQ.push_back({3'd7, r[7]});
            end
            HALT:    done = 1'b1;
            default: ;   // NOP and unused opcodes do nothing
         endcase
         pc = nextPc;
         steps++;
      end
   endfunction

   task automatic compareValue(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
      if (got !== exp) begin
         $display("FAILED %0t ns %s got %h expected %h", $time, name, got, exp);
         errCount++;
      end
   endtask

   // Each register write of the DUT is matched against the head of the model's list
   always @(posedge clk) begin
      if (!rst && retire.en) begin
         if (expQ.size() == 0) begin
            $display("Extra register write to R%0d at %0t ns that the model never made",
                     retire.addr, $time);
            errCount++;
         end else begin
            expEntry = expQ.pop_front();
            compareValue("retire.addr", 16'(retire.addr), 16'(expEntry[18:16]));
            compareValue("retire.data", retire.data, expEntry[15:0]);
         end
      end
   end

   always @(posedge clk) begin
      if (running) begin
         cycleCount++;
         if (cycleCount > cycleLimit) begin
            $display("Timeout after %0d cycles without the core halting", cycleLimit);
            $display("Test failures found");
            $finish;
         end
      end
   end

   // Load the image under reset, release the core and wait for halt
   task automatic runProgram(input string name);
      int errsBefore;
      errsBefore = errCount;
      buildExpected();
      @(negedge clk);
      rst = 1'b1;
      repeat (8) @(negedge clk);
      for (int i = 0; i < 256; i++) begin
         loadEn   = 1'b1;
         loadAddr = 16'(2 * i);   // Byte address of word i
         loadData = prog[i];
         @(negedge clk);
      end
      loadEn = 1'b0;
      rst = 1'b0;
      cycleLimit = progLen * 8 + 200;
      cycleCount = 0;
      running = 1'b1;
      while (halted !== 1'b1) @(posedge clk);
      repeat (10) @(negedge clk);   // Window for any write after halt
      running = 1'b0;
      if (expQ.size() != 0) begin
         $display("%s left %0d expected register writes unretired", name, expQ.size());
         errCount++;
      end
      $display("Test %s finished with %0d errors", name, errCount - errsBefore);
   endtask

   initial begin
      rst = 1'b1;
      loadEn = 1'b0;
      loadAddr = 16'h0000;
      loadData = 16'h0000;
      errCount = 0;
      running = 1'b0;
      cycleCount = 0;
      cycleLimit = 0;
      seedSink = $urandom(32'h193f);

      // ALU and immediates on random operands
      clearProgram();
      for (int k = 0; k < 8; k++) emit(byteImm(LBI, 3'(k), 8'($urandom)));
      for (int k = 0; k < 4; k++) emit(shortImm(ADDI, 3'($urandom), 3'($urandom), 5'($urandom)));
      for (int k = 0; k < 8; k++) begin
         emit(regOp(3'($urandom), 3'($urandom), 3'($urandom), aluFuncE'(2'(k))));
      end
      emit({HALT, 11'd0});
      runProgram("alu");

      // Stores then loads of the same word and of another word
      clearProgram();
      emit(byteImm(LBI, 3'd1, 8'h40));
      emit(regOp(3'd1, 3'd1, 3'd1, ADD));
      emit(regOp(3'd1, 3'd1, 3'd1, ADD));   // R1 points at byte 0x100
      for (int k = 0; k < 4; k++) begin
         off = 5'(2 * ($urandom % 8));
         emit(byteImm(LBI, 3'd2, 8'($urandom)));
         emit(shortImm(ST, 3'd1, 3'd2, off));
         emit(shortImm(LD, 3'd1, 3'd3, off));
         emit(shortImm(LD, 3'd1, 3'd4, off ^ 5'h12));   // Other word below R1
      end
      emit({HALT, 11'd0});
      runProgram("loadStore");

      // Every condition against a zero, a negative and a positive Rs
      clearProgram();
      emit(byteImm(LBI, 3'd1, 8'h00));
      emit(byteImm(LBI, 3'd2, 8'h80 | 8'($urandom)));
      emit(byteImm(LBI, 3'd3, 8'(1 + $urandom % 127)));
      for (int b = 0; b < 4; b++) begin
         for (int s = 1; s <= 3; s++) begin
            emit(byteImm(opcodeE'(5'b01100 + 5'(b)), 3'(s), 8'd2));   // Taken skips one
            emit(byteImm(LBI, 3'd4, 8'(16 * b + s)));
            emit(byteImm(LBI, 3'd5, 8'(16 * b + s + 8)));
         end
      end
      emit({HALT, 11'd0});
      runProgram("branch");

      // Jumps with the skipped words marked by writes to R0
      clearProgram();
      emit(longJump(J, 11'd2));
      emit(byteImm(LBI, 3'd0, 8'h11));
      emit(longJump(JAL, 11'd2));
      emit(byteImm(LBI, 3'd0, 8'h22));
      emit(byteImm(LBI, 3'd1, 8'd14));
      emit(byteImm(JR, 3'd1, 8'd2));   // Lands on word 8
      emit(byteImm(LBI, 3'd0, 8'h33));
      emit(byteImm(LBI, 3'd0, 8'h44));
      emit(byteImm(LBI, 3'd2, 8'd24));
      emit(byteImm(JALR, 3'd2, 8'hFE));   // Lands on word 11
      emit(byteImm(LBI, 3'd0, 8'h55));
      emit(longJump(J, 11'd4));
      emit(byteImm(LBI, 3'd0, 8'h66));
      emit({HALT, 11'd0});
      emit(byteImm(LBI, 3'd3, 8'h77));
      emit(longJump(J, 11'h7FA));   // Back to the HALT at word 13
      runProgram("jump");

      // Random mix, R6 stays the data base and R7 is never written
      clearProgram();
      emit(byteImm(LBI, 3'd6, 8'h40));
      emit(regOp(3'd6, 3'd6, 3'd6, ADD));
      emit(regOp(3'd6, 3'd6, 3'd6, ADD));
      for (int k = 0; k < 40; k++) begin
         case ($urandom % 5)
            0: emit(byteImm(LBI, 3'($urandom % 6), 8'($urandom)));
            1: emit(shortImm(ADDI, 3'($urandom), 3'($urandom % 6), 5'($urandom)));
            2: emit(regOp(3'($urandom), 3'($urandom), 3'($urandom % 6),
                          aluFuncE'(2'($urandom))));
            3: emit(shortImm(($urandom % 2) ? LD : ST, 3'd6, 3'($urandom % 6), 5'($urandom)));
            default: emit(byteImm(opcodeE'(5'b01100 + 5'($urandom % 4)), 3'($urandom),
                                  8'(2 + 2 * ($urandom % 3))));   // Forward by one to three
         endcase
      end
      for (int k = 0; k < 3; k++) emit({NOP, 11'd0});   // Landing room for late branches
      emit({HALT, 11'd0});
      runProgram("random");

      $display("Tests run: 5, errors: %0d", errCount);
      if (errCount == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule
`default_nettype wire

/* filelist.f */
hw/wiscPkg.sv
hw/regFile.sv
hw/decode.sv
hw/fetch.sv
hw/execute.sv
hw/memArbiter.sv
hw/sharedMem.sv
hw/cpuTop.sv
test/clockGen.sv
test/cpuTb.sv

/* Makefile */
SRCS := $(wildcard hw/*.sv test/*.sv)

obj_dir/VcpuTb: filelist.f $(SRCS)
	verilator --binary -Wno-fatal --top-module cpuTb -f filelist.f

run: obj_dir/VcpuTb
	./obj_dir/VcpuTb | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
